// ==== exec_settings.svh ====
// execute slice sizing for unit count, station depth, register file width and multiply latency
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// number of identical execution units
`define NUM_UNITS   3

// reservation station entries
`define RS_DEPTH    4

// physical registers, tag width follows from this
`define PR_COUNT    16

`define XLEN        32     // datapath width
`define ROB_BITS    4      // reorder buffer index width

// cycles from issue to result for op_mul
`define MUL_CYCLES  3

`endif

// ==== exec_pkg.sv ====
// execute slice types for opcodes, unit states and the dispatch, issue and broadcast packets
`include "exec_settings.svh"

package exec_pkg;

  // physical register tag
  typedef logic [$clog2(`PR_COUNT)-1:0] tag_t;

  // alu opcodes, op_mul is the only multi-cycle one
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_mul
  } alu_op_e;

  typedef enum logic [1:0] {
    unit_idle,   // free for issue
    unit_busy,   // computing
    unit_done    // result waits for cdb grant
  } unit_state_e;

  // renamed instruction from dispatch
  typedef struct packed {
    alu_op_e               op;
    tag_t                  dest;
    tag_t                  src1;
    tag_t                  src2;      // ignored when use_imm set
    logic                  use_imm;
    logic [`XLEN-1:0]      imm;
    logic [`ROB_BITS-1:0]  rob;
  } dispatch_packet_t;

  // issued op, operands already resolved
  typedef struct packed {
    alu_op_e               op;
    tag_t                  dest;
    logic [`XLEN-1:0]      opa;
    logic [`XLEN-1:0]      opb;
    logic [`ROB_BITS-1:0]  rob;
  } issue_packet_t;

  // one result on the common data bus
  typedef struct packed {
    tag_t                  dest;
    logic [`XLEN-1:0]      value;
    logic [`ROB_BITS-1:0]  rob;
  } cdb_packet_t;

endpackage

// ==== phys_regfile.sv ====
// physical register file with per-tag ready bits, two issue read ports and a cdb write port
`timescale 1ns/100ps
`include "exec_settings.svh"

module phys_regfile (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   alloc_valid,   // dispatch transfer
  input  exec_pkg::tag_t         alloc_tag,     // dest losing its ready bit
  input  exec_pkg::tag_t         read_tag_a,
  input  exec_pkg::tag_t         read_tag_b,
  output logic [`XLEN-1:0]       read_data_a,
  output logic [`XLEN-1:0]       read_data_b,
  input  exec_pkg::tag_t         src_tag_1,     // sources of the dispatching op
  input  exec_pkg::tag_t         src_tag_2,
  output logic                   src_ready_1,
  output logic                   src_ready_2,
  input  logic                   cdb_valid,
  input  exec_pkg::cdb_packet_t  cdb_packet
);
  import exec_pkg::*;

  logic [`XLEN-1:0]      regs [`PR_COUNT];
  logic [`PR_COUNT-1:0]  ready;

  // combinational reads, tag 0 is never written so reads zero
  assign read_data_a = regs[read_tag_a];
  assign read_data_b = regs[read_tag_b];
  assign src_ready_1 = ready[src_tag_1];
  assign src_ready_2 = ready[src_tag_2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `PR_COUNT; i++) begin
        regs[i] <= '0;
      end
      ready <= '1;                                // everything ready out of reset
    end else begin
      if (cdb_valid && cdb_packet.dest != tag_t'(0)) begin
        regs[cdb_packet.dest]  <= cdb_packet.value;
        ready[cdb_packet.dest] <= 1'b1;           // producer done
      end
      // new producer in flight, alloc after write so it wins
      if (alloc_valid && alloc_tag != tag_t'(0)) begin
        ready[alloc_tag] <= 1'b0;
      end
    end
  end

endmodule

// ==== reservation_station.sv ====
// reservation station holding dispatched ops, waking them from the cdb and issuing the oldest ready
`timescale 1ns/100ps
`include "exec_settings.svh"

module reservation_station (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dispatch_valid,
  input  exec_pkg::dispatch_packet_t  dispatch_packet,
  output logic                        dispatch_ready,
  output logic                        alloc_valid,
  output exec_pkg::tag_t              alloc_tag,
  output exec_pkg::tag_t              src_tag_1,
  output exec_pkg::tag_t              src_tag_2,
  input  logic                        src_ready_1,
  input  logic                        src_ready_2,
  output exec_pkg::tag_t              read_tag_a,
  output exec_pkg::tag_t              read_tag_b,
  input  logic [`XLEN-1:0]            read_data_a,
  input  logic [`XLEN-1:0]            read_data_b,
  input  logic [`NUM_UNITS-1:0]       unit_free,
  output logic [`NUM_UNITS-1:0]       issue_valid,   // one-hot on the lowest free unit
  output exec_pkg::issue_packet_t     issue_packet,
  input  logic                        cdb_valid,
  input  exec_pkg::cdb_packet_t       cdb_packet
);
  import exec_pkg::*;

  localparam int idx_bits = ($clog2(`RS_DEPTH) > 0) ? $clog2(`RS_DEPTH) : 1;

  dispatch_packet_t      entry [`RS_DEPTH];
  logic [idx_bits-1:0]   entry_age [`RS_DEPTH];    // valid entries younger than this one
  logic [`RS_DEPTH-1:0]  entry_valid;
  logic [`RS_DEPTH-1:0]  entry_rdy1;
  logic [`RS_DEPTH-1:0]  entry_rdy2;
  logic [`RS_DEPTH-1:0]  entry_ready;
  logic [`RS_DEPTH-1:0]  valid_next;
  logic [`RS_DEPTH-1:0]  older_than_sel;
  logic [idx_bits-1:0]   sel_idx;
  logic                  sel_found;
  logic [idx_bits-1:0]   free_idx;
  logic                  issue_fire;
  logic                  new_rdy1;
  logic                  new_rdy2;

  // broadcast this cycle for a real tag
  function automatic logic tag_hit(input tag_t tag, input logic valid, input cdb_packet_t pkt);
    return valid && tag != tag_t'(0) && tag == pkt.dest;
  endfunction

  ////////////////////////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////////////////////////
  assign alloc_valid = dispatch_valid && dispatch_ready;
  assign alloc_tag   = dispatch_packet.dest;
  assign src_tag_1   = dispatch_packet.src1;
  assign src_tag_2   = dispatch_packet.src2;
  assign new_rdy1    = src_ready_1 || tag_hit(src_tag_1, cdb_valid, cdb_packet);
  assign new_rdy2    = dispatch_packet.use_imm || src_ready_2
                       || tag_hit(src_tag_2, cdb_valid, cdb_packet);

  // lowest empty slot
  always_comb begin
    free_idx = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!entry_valid[i]) free_idx = idx_bits'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // select and issue
  ////////////////////////////////////////////////////////////
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      entry_ready[i] = entry_valid[i]
                       && (entry_rdy1[i] || tag_hit(entry[i].src1, cdb_valid, cdb_packet))
                       && (entry_rdy2[i] || tag_hit(entry[i].src2, cdb_valid, cdb_packet));
      if (entry_ready[i] && (!sel_found || entry_age[i] > entry_age[sel_idx])) begin
        sel_found = 1'b1;                          // oldest so far
        sel_idx   = idx_bits'(i);
      end
    end
  end

  assign issue_fire  = sel_found && |unit_free;
  assign issue_valid = sel_found ? (unit_free & (~unit_free + 1'b1)) : '0;  // lowest set bit

  // entries older than the issuing one lose a younger entry
  always_comb begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      older_than_sel[i] = issue_fire && entry_age[i] > entry_age[sel_idx];
    end
  end

  assign read_tag_a = entry[sel_idx].src1;
  assign read_tag_b = entry[sel_idx].src2;

  // operands from regfile or bypassed off the bus this cycle
  always_comb begin
    issue_packet.op   = entry[sel_idx].op;
    issue_packet.dest = entry[sel_idx].dest;
    issue_packet.rob  = entry[sel_idx].rob;
    issue_packet.opa  = tag_hit(read_tag_a, cdb_valid, cdb_packet) ? cdb_packet.value
                                                                   : read_data_a;
    if (entry[sel_idx].use_imm) begin
      issue_packet.opb = entry[sel_idx].imm;
    end else begin
      issue_packet.opb = tag_hit(read_tag_b, cdb_valid, cdb_packet) ? cdb_packet.value
                                                                     : read_data_b;
    end
  end

  always_comb begin
    valid_next = entry_valid;
    if (issue_fire) valid_next[sel_idx] = 1'b0;   // freed on issue
    if (alloc_valid) valid_next[free_idx] = 1'b1;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid    <= '0;
      entry_rdy1     <= '0;
      entry_rdy2     <= '0;
      dispatch_ready <= 1'b0;
      for (int i = 0; i < `RS_DEPTH; i++) begin
        entry_age[i] <= '0;
      end
    end else begin
      entry_valid    <= valid_next;
      dispatch_ready <= ~&valid_next;              // free slot next cycle
      for (int i = 0; i < `RS_DEPTH; i++) begin
        // wake-up by tag match
        if (tag_hit(entry[i].src1, cdb_valid, cdb_packet)) entry_rdy1[i] <= 1'b1;
        if (tag_hit(entry[i].src2, cdb_valid, cdb_packet)) entry_rdy2[i] <= 1'b1;
        if (entry_valid[i]) begin
          // new entry is younger than all, issue removes one younger from older ones
          if (alloc_valid && !older_than_sel[i]) begin
            entry_age[i] <= entry_age[i] + 1'b1;
          end else if (!alloc_valid && older_than_sel[i]) begin
            entry_age[i] <= entry_age[i] - 1'b1;
          end
        end
      end
      if (alloc_valid) begin
        entry_rdy1[free_idx] <= new_rdy1;
        entry_rdy2[free_idx] <= new_rdy2;
        entry_age[free_idx]  <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_valid) entry[free_idx] <= dispatch_packet;
  end

endmodule

// ==== exec_unit.sv ====
// execution unit running single-cycle alu ops and a multi-cycle multiply, holding results for the cdb
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_valid,
  input  exec_pkg::issue_packet_t  issue_packet,
  output logic                     unit_free,
  output logic                     done_valid,
  output exec_pkg::cdb_packet_t    done_packet,
  input  logic                     done_grant
);
  import exec_pkg::*;

  localparam int cnt_bits = $clog2(`MUL_CYCLES + 1);

  unit_state_e          state;
  logic [cnt_bits-1:0]  count;      // cycles left before the result lands
  issue_packet_t        held;       // op captured at issue
  logic [`XLEN-1:0]     result;

  assign unit_free  = (state == unit_idle);
  assign done_valid = (state == unit_done);   // held until granted

  always_comb begin
    case (held.op)
      op_add:  result = held.opa + held.opb;
      op_sub:  result = held.opa - held.opb;
      op_and:  result = held.opa & held.opb;
      op_or:   result = held.opa | held.opb;
      op_xor:  result = held.opa ^ held.opb;
      op_sll:  result = held.opa << held.opb[4:0];
      op_mul:  result = held.opa * held.opb;     // low XLEN bits of product
      default: result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // unit fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= unit_idle;
      count <= '0;
    end else begin
      case (state)
        unit_idle: if (issue_valid) begin
          state <= unit_busy;
          count <= (issue_packet.op == op_mul) ? cnt_bits'(`MUL_CYCLES - 1) : '0;
        end
        unit_busy: if (count == '0) state <= unit_done;
                   else count <= count - 1'b1;
        unit_done: if (done_grant) state <= unit_idle;  // bus took it
        default:   state <= unit_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == unit_idle && issue_valid) held <= issue_packet;
    if (state == unit_busy && count == '0) begin
      done_packet.dest  <= held.dest;
      done_packet.value <= result;
      done_packet.rob   <= held.rob;
    end
  end

endmodule

// ==== cdb_arbiter.sv ====
// round-robin cdb arbiter granting one finished unit per cycle onto a registered broadcast
`timescale 1ns/100ps
`include "exec_settings.svh"

module cdb_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [`NUM_UNITS-1:0]    done_valid,
  input  exec_pkg::cdb_packet_t    done_packet [`NUM_UNITS],
  output logic [`NUM_UNITS-1:0]    done_grant,
  output logic                     cdb_valid,
  output exec_pkg::cdb_packet_t    cdb_packet
);
  import exec_pkg::*;

  localparam int ptr_bits = ($clog2(`NUM_UNITS) > 0) ? $clog2(`NUM_UNITS) : 1;

  logic [ptr_bits-1:0]  ptr;          // first unit looked at
  logic [ptr_bits-1:0]  grant_idx;
  logic                 found;
  cdb_packet_t          granted_packet;

  // scan from ptr, wrapping
  always_comb begin
    int idx;
    found     = 1'b0;
    grant_idx = ptr;
    for (int j = 0; j < `NUM_UNITS; j++) begin
      idx = (int'(ptr) + j) % `NUM_UNITS;
      if (!found && done_valid[idx]) begin
        found     = 1'b1;
        grant_idx = ptr_bits'(idx);
      end
    end
    done_grant = '0;
    if (found) done_grant[grant_idx] = 1'b1;   // one grant per cycle
  end

  assign granted_packet = done_packet[grant_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
      ptr       <= '0;
    end else begin
      cdb_valid <= found;
      // move past the winner
      if (found) ptr <= (grant_idx == ptr_bits'(`NUM_UNITS - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (found) cdb_packet <= granted_packet;
  end

endmodule

// ==== exec_core.sv ====
// execute and complete slice top joining station, register file, execution units and cdb arbiter
`timescale 1ns/100ps
`include "exec_settings.svh"

module exec_core (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dispatch_valid,
  input  exec_pkg::dispatch_packet_t  dispatch_packet,
  output logic                        dispatch_ready,
  output logic                        complete_valid,
  output exec_pkg::cdb_packet_t       complete_packet
);
  import exec_pkg::*;

  // station <-> regfile
  logic                   alloc_valid;
  tag_t                   alloc_tag;
  tag_t                   src_tag_1;
  tag_t                   src_tag_2;
  logic                   src_ready_1;
  logic                   src_ready_2;
  tag_t                   read_tag_a;
  tag_t                   read_tag_b;
  logic [`XLEN-1:0]       read_data_a;
  logic [`XLEN-1:0]       read_data_b;

  // issue and done
  logic [`NUM_UNITS-1:0]  unit_free;
  logic [`NUM_UNITS-1:0]  issue_valid;
  issue_packet_t          issue_packet;   // shared by all units
  logic [`NUM_UNITS-1:0]  done_valid;
  logic [`NUM_UNITS-1:0]  done_grant;
  cdb_packet_t            done_packet [`NUM_UNITS];

  logic                   cdb_valid;
  cdb_packet_t            cdb_packet;

  phys_regfile phys_regfile_i (
    .clock(clock), .reset(reset),
    .alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
    .read_tag_a(read_tag_a), .read_tag_b(read_tag_b),
    .read_data_a(read_data_a), .read_data_b(read_data_b),
    .src_tag_1(src_tag_1), .src_tag_2(src_tag_2),
    .src_ready_1(src_ready_1), .src_ready_2(src_ready_2),
    .cdb_valid(cdb_valid), .cdb_packet(cdb_packet)
  );

  reservation_station reservation_station_i (
    .clock(clock), .reset(reset),
    .dispatch_valid(dispatch_valid), .dispatch_packet(dispatch_packet),
    .dispatch_ready(dispatch_ready),
    .alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
    .src_tag_1(src_tag_1), .src_tag_2(src_tag_2),
    .src_ready_1(src_ready_1), .src_ready_2(src_ready_2),
    .read_tag_a(read_tag_a), .read_tag_b(read_tag_b),
    .read_data_a(read_data_a), .read_data_b(read_data_b),
    .unit_free(unit_free), .issue_valid(issue_valid), .issue_packet(issue_packet),
    .cdb_valid(cdb_valid), .cdb_packet(cdb_packet)
  );

  for (genvar u = 0; u < `NUM_UNITS; u++) begin : g_unit
    exec_unit exec_unit_i (
      .clock(clock), .reset(reset),
      .issue_valid(issue_valid[u]), .issue_packet(issue_packet),
      .unit_free(unit_free[u]),
      .done_valid(done_valid[u]), .done_packet(done_packet[u]),
      .done_grant(done_grant[u])
    );
  end

  cdb_arbiter cdb_arbiter_i (
    .clock(clock), .reset(reset),
    .done_valid(done_valid), .done_packet(done_packet), .done_grant(done_grant),
    .cdb_valid(cdb_valid), .cdb_packet(cdb_packet)
  );

  // rob side sees every broadcast
  assign complete_valid  = cdb_valid;
  assign complete_packet = cdb_packet;

endmodule

// ==== tb_exec_core.sv ====
// table driven testbench for the execute slice with a reference model and a completion monitor
`timescale 1ns/100ps
`include "exec_settings.svh"

module tb_exec_core;
  import exec_pkg::*;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  dispatch_packet_t      dispatch_packet;
  logic                  dispatch_ready;
  logic                  complete_valid;
  cdb_packet_t           complete_packet;

  dispatch_packet_t      table_pkt [$];          // stimulus in program order
  logic [`XLEN-1:0]      table_exp [$];          // expected dest value per entry
  logic [`XLEN-1:0]      model_regs [`PR_COUNT]; // reference tag values
  int                    seen_count [`PR_COUNT];
  logic [`XLEN-1:0]      seen_value [`PR_COUNT];
  logic [`ROB_BITS-1:0]  seen_rob [`PR_COUNT];
  int                    total_seen;
  int                    total_sent;
  int                    errors;
  int                    test_errors;
  int                    tests_run;
  logic                  timed_out;
  integer                seed;

  exec_core exec_core_i (
    .clock(clock), .reset(reset),
    .dispatch_valid(dispatch_valid), .dispatch_packet(dispatch_packet),
    .dispatch_ready(dispatch_ready),
    .complete_valid(complete_valid), .complete_packet(complete_packet)
  );

  always #10 clock = ~clock;   // 20 ns period

  // completion monitor with one record per tag
  always @(posedge clock) begin
    if (!reset && complete_valid) begin
      seen_count[complete_packet.dest] = seen_count[complete_packet.dest] + 1;
      seen_value[complete_packet.dest] = complete_packet.value;
      seen_rob[complete_packet.dest]   = complete_packet.rob;
      total_seen = total_seen + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [`XLEN-1:0] alu_model(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    logic [2*`XLEN-1:0] wide;
    wide = '0;
    case (op)
      op_add:  wide = a + b;
      op_sub:  wide = a + ~b + 1'b1;        // two's complement
      op_and:  wide = a & b;
      op_or:   wide = a | b;
      op_xor:  wide = (a | b) & ~(a & b);
      op_sll:  wide = a * (64'd1 << b[4:0]);
      op_mul:  wide = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
      default: wide = '0;
    endcase
    return wide[`XLEN-1:0];                 // truncate to datapath width
  endfunction

  // append one entry and run it through the model in program order
  task automatic add_instr(alu_op_e op, tag_t dest, tag_t src1, tag_t src2, logic use_imm,
                           logic [`XLEN-1:0] imm);
    dispatch_packet_t p;
    p.op      = op;
    p.dest    = dest;
    p.src1    = src1;
    p.src2    = use_imm ? tag_t'(0) : src2;
    p.use_imm = use_imm;
    p.imm     = imm;
    p.rob     = `ROB_BITS'(table_pkt.size() + 5);
    model_regs[dest] = alu_model(op, model_regs[src1], use_imm ? imm : model_regs[src2]);
    table_pkt.push_back(p);
    table_exp.push_back(model_regs[dest]);
  endtask

  // earlier dest of the round or one of tags 11..15
  function automatic tag_t pick_source(int k, int i);
    return (k < i) ? tag_t'(1 + k) : tag_t'(11 + k - i);
  endfunction

  task automatic check_value(string what, logic [`XLEN-1:0] actual,
                             logic [`XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      errors = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and completion waits
  ////////////////////////////////////////////////////////////
  task automatic do_reset();
    @(posedge clock);
    reset <= 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
  endtask

  // one entry per transfer held until ready
  task automatic send_table();
    int waited;
    for (int i = 0; i < table_pkt.size() && !timed_out; i++) begin
      dispatch_valid  <= 1'b1;
      dispatch_packet <= table_pkt[i];
      waited = 0;
      do begin
        @(posedge clock);                   // ready read before the edge updates it
        waited++;
      end while (!dispatch_ready && waited < 200);
      if (!dispatch_ready) begin
        $display("Dispatch of entry %0d for tag %0d was never accepted", i, table_pkt[i].dest);
        timed_out = 1'b1;
      end else begin
        total_sent = total_sent + 1;
      end
    end
    dispatch_valid <= 1'b0;
  endtask

  task automatic wait_done();
    int waited;
    bit all_seen;
    waited   = 0;
    all_seen = 1'b0;
    while (!all_seen && waited < 500) begin
      @(negedge clock);                     // monitor settled by now
      waited++;
      all_seen = 1'b1;
      foreach (table_pkt[i]) if (seen_count[table_pkt[i].dest] == 0) all_seen = 1'b0;
    end
    if (!all_seen) begin
      foreach (table_pkt[i]) begin
        if (seen_count[table_pkt[i].dest] == 0)
          $display("Tag %0d never completed", table_pkt[i].dest);
      end
      timed_out = 1'b1;
    end
  endtask

  task automatic run_table(int num, string name);
    tag_t d;
    if (timed_out) return;
    foreach (seen_count[t]) seen_count[t] = 0;
    @(posedge clock);
    send_table();
    if (!timed_out) wait_done();
    if (!timed_out) begin
      foreach (table_pkt[i]) begin
        d = table_pkt[i].dest;
        check_value($sformatf("completions of tag %0d", d), seen_count[d], 1);
        check_value($sformatf("value of tag %0d", d), seen_value[d], table_exp[i]);
        check_value($sformatf("rob of tag %0d", d), seen_rob[d], table_pkt[i].rob);
      end
    end
    $display("test %0d %s: %0d entries, %0d errors", num, name, table_pkt.size(), test_errors);
    tests_run   = tests_run + 1;
    test_errors = 0;
    table_pkt.delete();
    table_exp.delete();
  endtask

  // nothing may complete while idle
  task automatic check_idle_after_reset();
    int waited;
    do_reset();
    foreach (model_regs[t]) model_regs[t] = '0;   // regfile cleared too
    waited = 0;
    while (!dispatch_ready && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (!dispatch_ready) begin
      $display("dispatch_ready never rose after reset");
      timed_out = 1'b1;
    end
    repeat (10) begin
      @(posedge clock);
      check_value("complete_valid while idle", complete_valid, 1'b0);
      check_value("dispatch_ready while idle", dispatch_ready, 1'b1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clock = 1'b0;
    reset = 1'b1;
    dispatch_valid  = 1'b0;
    dispatch_packet = '0;
    total_seen = 0;
    total_sent = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    timed_out = 1'b0;
    seed = 32;
    foreach (model_regs[t]) model_regs[t] = '0;
    do_reset();

    // every opcode against tag 0
    for (int k = 0; k < 7; k++) begin
      add_instr(alu_op_e'(k), tag_t'(k + 1), 0, 0, 1, 32'h0f0f_1234 + k);
    end
    run_table(1, "immediate ops");

    // each op reads the one before
    add_instr(op_add, 8, 0, 0, 1, 32'd1000);
    add_instr(op_sll, 9, 8, 0, 1, 32'd3);
    add_instr(op_sub, 10, 9, 8, 0, 0);
    add_instr(op_mul, 11, 10, 9, 0, 0);
    add_instr(op_xor, 12, 11, 0, 1, 32'h5a5a_5a5a);
    add_instr(op_or, 13, 12, 10, 0, 0);
    run_table(2, "dependent chain");

    add_instr(op_mul, 14, 11, 10, 0, 0);  // adds may finish first
    for (int k = 0; k < 4; k++) add_instr(op_add, tag_t'(k + 1), tag_t'(k + 8), 0, 1, k * 7);
    run_table(3, "multiply then adds");

    // fills the station behind the multiply
    add_instr(op_mul, 15, 13, 0, 1, 32'd3);
    for (int k = 0; k <= `RS_DEPTH; k++) begin
      add_instr(alu_op_e'(k % 6), tag_t'(5 + k), 15, 12, 0, 0);
    end
    run_table(4, "back-pressure");

    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 10; i++) begin
        add_instr(alu_op_e'($unsigned($random(seed)) % 7), tag_t'(1 + i),
                  pick_source($unsigned($random(seed)) % (i + 5), i),
                  pick_source($unsigned($random(seed)) % (i + 5), i),
                  $random(seed) & 1, $random(seed));
      end
      run_table(5, "random table");
    end

    if (!timed_out) check_idle_after_reset();
    add_instr(op_add, 1, 0, 0, 1, 32'd77);
    run_table(6, "idle after reset");

    $display("%0d tests, %0d errors, %0d of %0d instructions completed",
             tests_run, errors, total_seen, total_sent);
    if (errors == 0 && !timed_out && total_seen == total_sent) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
exec_pkg.sv
phys_regfile.sv
reservation_station.sv
exec_unit.sv
cdb_arbiter.sv
exec_core.sv
tb_exec_core.sv
